// File: design/erx_macros.svh
`ifndef ERX_MACROS_SVH
`define ERX_MACROS_SVH

//####################
// Receive path sizing
//####################

// Heartbeat counter width
// One beat every 2**ERX_RCW cycles
`define ERX_RCW          4

`define ERX_NLANES       4        // Striped lanes
`define ERX_LANE_DEPTH   4        // Entries per lane, also credits per lane

// Whole buffer worth of source credits
`define ERX_SRC_CREDITS  (`ERX_NLANES * `ERX_LANE_DEPTH)

`define ERX_BYTE_W       8        // Received byte

`endif

// File: design/erx_pkg.sv
`include "erx_macros.svh"

package erx_pkg;

   //####################
   // Scalar types
   //####################

   typedef logic [`ERX_BYTE_W-1:0]         erx_data_t;     // One byte of payload
   typedef logic [$clog2(`ERX_NLANES)-1:0] erx_lane_idx_t; // Round-robin lane index

   //####################
   // Reset sequencer
   //####################

   // Sequencer states, stepped on heartbeat only
   typedef enum logic [1:0] {
      RESET_ALL = 2'd0,   // PLL held in reset
      START_PLL = 2'd1,   // Waiting for lock and delay cal
      ACTIVE    = 2'd2    // Datapath running
   } erx_state_e;

   //####################
   // Datapath bundles
   //####################

   // Byte on the source, sink and lane head links
   typedef struct packed {
      logic      valid;   // Byte present this cycle
      erx_data_t data;
   } erx_byte_t;

   // Distributor to lane write port
   typedef struct packed {
      logic      push;    // Write into the lane FIFO
      erx_data_t data;
   } erx_slot_t;

endpackage

// File: design/erx_reset_seq.sv
`timescale 1ns/1ps
`include "erx_macros.svh"

module erx_reset_seq
   import erx_pkg::*;
(
   input  logic sys_clk,
   input  logic rx_nreset_in,
   input  logic soft_reset,      // Software hold, high keeps rx down
   input  logic pll_locked,      // Lock from PLL, not yet synced
   input  logic idelay_ready,    // Delay calibration done
   output logic rx_active,
   output logic pll_reset
);

   logic [`ERX_RCW-1:0] hb_cnt;         // Free running
   logic                heartbeat;      // One cycle per wrap
   logic                lock_meta;      // Sync stage 1
   logic                lock_sync;      // Sync stage 2
   erx_state_e          state;

   //####################
   // Heartbeat
   //####################

   // Counter wraps every 2**RCW cycles
   // Heartbeat is high in the cycle the count sits at zero
   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         hb_cnt    <= '0;
         heartbeat <= 1'b0;
      end
      else
      begin
         hb_cnt    <= hb_cnt + 1'b1;
         heartbeat <= &hb_cnt;      // About to wrap
      end
   end

   //####################
   // Lock synchronizer
   //####################

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         lock_meta <= 1'b0;
         lock_sync <= 1'b0;
      end
      else
      begin
         lock_meta <= pll_locked;
         lock_sync <= lock_meta;
      end
   end

   //####################
   // Sequencer FSM
   //####################

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
         state <= RESET_ALL;
      else if (heartbeat)     // Only moves on a beat
      begin
         case (state)
            RESET_ALL :
               if (!soft_reset)
                  state <= START_PLL;
            START_PLL :
               if (lock_sync && idelay_ready)
                  state <= ACTIVE;       // PLL up and delays calibrated
            ACTIVE :
               if (soft_reset)
                  state <= RESET_ALL;    // Back to the start
            default :
               state <= RESET_ALL;       // Unused encoding
         endcase
      end
   end

   // Decoded outputs
   assign rx_active = (state == ACTIVE);
   assign pll_reset = (state == RESET_ALL);

endmodule

// File: design/erx_lane_dist.sv
`timescale 1ns/1ps
`include "erx_macros.svh"

module erx_lane_dist
   import erx_pkg::*;
(
   input  logic                    sys_clk,
   input  logic                    rx_nreset_in,
   input  logic                    rx_active,
   input  erx_byte_t               in_byte,                 // From source
   output erx_slot_t               slot [`ERX_NLANES],      // One write port per lane
   input  logic [`ERX_NLANES-1:0]  lane_credit              // Pulse per lane pop
);

   localparam int CW = $clog2(`ERX_LANE_DEPTH + 1);

   erx_lane_idx_t           wr_lane;                     // Round-robin pointer
   logic [CW-1:0]           lane_cnt [`ERX_NLANES];      // Credits held per lane
   logic                    accept;
   logic [`ERX_NLANES-1:0]  push_q;
   erx_data_t               data_q;

   // Take the byte only when the target lane has room
   // Source credits keep this true in normal traffic
   assign accept = rx_active & in_byte.valid & (lane_cnt[wr_lane] != '0);

   //####################
   // Control registers
   //####################

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         wr_lane <= '0;
         push_q  <= '0;
         for (int k = 0; k < `ERX_NLANES; k++)
            lane_cnt[k] <= CW'(`ERX_LANE_DEPTH);
      end
      else if (!rx_active)
      begin
         wr_lane <= '0;                               // Restart at lane 0
         push_q  <= '0;
         for (int k = 0; k < `ERX_NLANES; k++)
            lane_cnt[k] <= CW'(`ERX_LANE_DEPTH);     // Lanes are flushed too
      end
      else
      begin
         for (int k = 0; k < `ERX_NLANES; k++)
         begin
            push_q[k]   <= accept && (wr_lane == erx_lane_idx_t'(k));
            lane_cnt[k] <= lane_cnt[k]
                         - CW'(accept && (wr_lane == erx_lane_idx_t'(k)))
                         + CW'(lane_credit[k]);       // Pop returns one
         end
         if (accept)
            wr_lane <= (wr_lane == erx_lane_idx_t'(`ERX_NLANES - 1)) ?
                       '0 : wr_lane + 1'b1;
      end
   end

   // Payload shared by all lanes, push picks the target
   always_ff @(posedge sys_clk)
      data_q <= in_byte.data;

   always_comb
   begin
      for (int k = 0; k < `ERX_NLANES; k++)
         slot[k] = '{push: push_q[k], data: data_q};
   end

endmodule

// File: design/erx_lane.sv
`timescale 1ns/1ps
`include "erx_macros.svh"

module erx_lane
   import erx_pkg::*;
(
   input  logic      sys_clk,
   input  logic      rx_nreset_in,
   input  logic      flush,          // Drop everything, no credits back
   input  erx_slot_t slot,           // Write side from distributor
   input  logic      pop,            // Read strobe from merger
   output erx_byte_t head,           // Oldest entry and not-empty flag
   output logic      lane_credit     // One per entry popped
);

   localparam int AW = $clog2(`ERX_LANE_DEPTH);
   localparam int CW = $clog2(`ERX_LANE_DEPTH + 1);

   erx_data_t      mem [`ERX_LANE_DEPTH];
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [CW-1:0]  count;            // Occupancy
   logic           not_empty;
   logic           not_full;
   logic           do_push;
   logic           do_pop;

   assign not_empty = (count != '0);
   assign not_full  = (count != CW'(`ERX_LANE_DEPTH));

   // Flush wins over both ports
   assign do_push = slot.push & not_full & ~flush;
   assign do_pop  = pop & not_empty & ~flush;

   //####################
   // Pointers and count
   //####################

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (flush)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;        // Contents lost
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == AW'(`ERX_LANE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == AW'(`ERX_LANE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + CW'(do_push) - CW'(do_pop);
      end
   end

   // Storage
   always_ff @(posedge sys_clk)
   begin
      if (do_push)
         mem[wr_ptr] <= slot.data;
   end

   assign head        = '{valid: not_empty & ~flush, data: mem[rd_ptr]};
   assign lane_credit = do_pop;     // Same cycle as the pop

endmodule

// File: design/erx_lane_merge.sv
`timescale 1ns/1ps
`include "erx_macros.svh"

module erx_lane_merge
   import erx_pkg::*;
(
   input  logic                    sys_clk,
   input  logic                    rx_nreset_in,
   input  logic                    rx_active,
   input  erx_byte_t               head [`ERX_NLANES],   // Lane heads
   output logic [`ERX_NLANES-1:0]  pop,
   input  logic                    out_credit,           // Sink grants one byte
   output erx_byte_t               out_byte,             // To sink
   output logic                    in_credit             // Back to source
);

   erx_lane_idx_t  rd_lane;          // Follows the distributor order
   logic [7:0]     sink_cnt;         // Sink credits held
   logic           take;
   logic           credit_inc;
   logic           stage_v;          // Popped byte, stage 2
   erx_data_t      stage_d;
   logic           out_v;            // Output register, stage 3
   erx_data_t      out_d;
   logic           credit_q;         // Source credit return, stage 3

   // Pop only the lane in turn, and only with a sink credit
   assign take       = rx_active & head[rd_lane].valid & (sink_cnt != '0);
   assign credit_inc = out_credit & (sink_cnt != 8'hff);   // Saturate

   always_comb
   begin
      for (int k = 0; k < `ERX_NLANES; k++)
         pop[k] = take && (rd_lane == erx_lane_idx_t'(k));
   end

   //####################
   // Control registers
   //####################

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         rd_lane  <= '0;
         sink_cnt <= '0;
         stage_v  <= 1'b0;
         out_v    <= 1'b0;
         credit_q <= 1'b0;
      end
      else if (!rx_active)
      begin
         rd_lane  <= '0;         // Match distributor restart
         sink_cnt <= '0;         // Credits in flight are dropped
         stage_v  <= 1'b0;
         out_v    <= 1'b0;
         credit_q <= 1'b0;
      end
      else
      begin
         if (take)
            rd_lane <= (rd_lane == erx_lane_idx_t'(`ERX_NLANES - 1)) ?
                       '0 : rd_lane + 1'b1;
         sink_cnt <= sink_cnt - 8'(take) + 8'(credit_inc);
         stage_v  <= take;
         out_v    <= stage_v;
         credit_q <= stage_v;    // Lines up with the output register
      end
   end

   // Payload pipe
   always_ff @(posedge sys_clk)
   begin
      stage_d <= head[rd_lane].data;
      out_d   <= stage_d;
   end

   // Nothing leaves once the sequencer drops out of ACTIVE
   assign out_byte  = '{valid: out_v & rx_active, data: out_d};
   assign in_credit = credit_q & rx_active;     // Source credit per byte out

endmodule

// File: design/erx_top.sv
`timescale 1ns/1ps
`include "erx_macros.svh"

module erx_top
   import erx_pkg::*;
(
   input  logic      sys_clk,
   input  logic      rx_nreset_in,
   input  logic      soft_reset,
   input  logic      pll_locked,
   input  logic      idelay_ready,
   input  erx_byte_t in_byte,          // Source link
   output logic      in_credit,
   output erx_byte_t out_byte,         // Sink link
   input  logic      out_credit,
   output logic      rx_active,
   output logic      pll_reset
);

   erx_slot_t               slot [`ERX_NLANES];    // Distributor to lanes
   erx_byte_t               head [`ERX_NLANES];    // Lanes to merger
   logic [`ERX_NLANES-1:0]  pop;
   logic [`ERX_NLANES-1:0]  lane_credit;

   //####################
   // Sequencer
   //####################

   erx_reset_seq i_reset_seq (
      .sys_clk      (sys_clk),
      .rx_nreset_in (rx_nreset_in),
      .soft_reset   (soft_reset),
      .pll_locked   (pll_locked),
      .idelay_ready (idelay_ready),
      .rx_active    (rx_active),
      .pll_reset    (pll_reset)
   );

   //####################
   // Striped buffer
   //####################

   erx_lane_dist i_dist (
      .sys_clk      (sys_clk),
      .rx_nreset_in (rx_nreset_in),
      .rx_active    (rx_active),
      .in_byte      (in_byte),
      .slot         (slot),
      .lane_credit  (lane_credit)
   );

   // Lanes flush together whenever rx is down
   for (genvar k = 0; k < `ERX_NLANES; k++)
   begin : g_lane
      erx_lane i_lane (
         .sys_clk      (sys_clk),
         .rx_nreset_in (rx_nreset_in),
         .flush        (~rx_active),
         .slot         (slot[k]),
         .pop          (pop[k]),
         .head         (head[k]),
         .lane_credit  (lane_credit[k])
      );
   end

   erx_lane_merge i_merge (
      .sys_clk      (sys_clk),
      .rx_nreset_in (rx_nreset_in),
      .rx_active    (rx_active),
      .head         (head),
      .pop          (pop),
      .out_credit   (out_credit),
      .out_byte     (out_byte),
      .in_credit    (in_credit)
   );

endmodule

// File: dv/erx_sva.sv
`timescale 1ns/1ps

module erx_sva
   import erx_pkg::*;
(
   input logic      sys_clk,
   input logic      rx_nreset_in,
   input logic      pll_locked,
   input logic      rx_active,
   input logic      in_credit,
   input erx_byte_t out_byte
);

   logic lock_seen;      // Sticky, PLL has reported lock at least once

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
         lock_seen <= 1'b0;
      else if (pll_locked)
         lock_seen <= 1'b1;
   end

   //####################
   // Sequencer and credit rules
   //####################

   // Activation only after a lock
   a_lock_first : assert property (@(posedge sys_clk) disable iff (!rx_nreset_in)
      $rose(rx_active) |-> lock_seen)
      else $error("rx_active rose before pll_locked was ever high");

   // Quiet link while down
   a_quiet_down : assert property (@(posedge sys_clk) disable iff (!rx_nreset_in)
      !rx_active |-> (!out_byte.valid && !in_credit))
      else $error("output or source credit while rx_active is low");

   // One source credit per delivered byte, same cycle
   a_credit_eq : assert property (@(posedge sys_clk) disable iff (!rx_nreset_in)
      in_credit == out_byte.valid)
      else $error("in_credit differs from out_byte valid");

endmodule

bind erx_top erx_sva i_sva (.*);

// File: dv/erx_tb.sv
`timescale 1ns/1ps
`include "erx_macros.svh"

module erx_tb
   import erx_pkg::*;
();

   logic      sys_clk;
   logic      rx_nreset_in;
   logic      soft_reset = 1'b1;
   logic      pll_locked = 1'b0;
   logic      idelay_ready = 1'b0;
   erx_byte_t in_byte = '0;
   logic      in_credit;
   erx_byte_t out_byte;
   logic      out_credit = 1'b0;
   logic      rx_active;
   logic      pll_reset;

   integer    seed = 32'hc511;
   erx_data_t exp_q [$];              // Sent, not yet delivered
   int        src_cnt = 0;            // Source credits held
   int        sent = 0;
   int        send_lim = 0;           // Source stops once sent reaches this
   int        snk_rate = 0;           // Sink grant chance, percent
   int        dlv_cnt = 0;            // Bytes delivered
   int        ret_cnt = 0;            // Source credits returned
   int        checks = 0;
   int        errors = 0;
   logic      prev_active = 1'b0;
   logic      ctl_soft = 1'b1;        // Requested levels, driven at negedge
   logic      ctl_lock = 1'b0;
   logic      ctl_idly = 1'b0;

   initial sys_clk = 1'b0;
   always #20 sys_clk = ~sys_clk;     // 40 ns period

   erx_top i_dut (.*);

   //####################
   // Compare tasks
   //####################

   task automatic check_byte(input string name, input erx_byte_t exp, input erx_byte_t got);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic check_state(input string name, input logic exp, input logic got);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t %s exp %b got %b", $time, name, exp, got);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int got);
      checks++;
      if (got != exp)
      begin
         errors++;
         $display("ERR %0t %s exp %0d got %0d", $time, name, exp, got);
      end
   endtask

   // Just past the falling edge, driver has already run
   task automatic step();
      @(negedge sys_clk);
      #1;
   endtask

   task automatic wait_active(input logic level, input int limit);
      int n;
      n = 0;
      while (rx_active !== level && n < limit)
      begin
         step();
         n++;
      end
      if (rx_active !== level)
      begin
         errors++;
         $display("%0t rx_active never went to %b in %0d cycles", $time, level, limit);
      end
   endtask

   // Source done and every sent byte seen at the sink
   task automatic wait_drain();
      int n;
      n = 0;
      while ((sent < send_lim || exp_q.size() != 0) && n < 2000)
      begin
         step();
         n++;
      end
      if (sent < send_lim || exp_q.size() != 0)
      begin
         errors++;
         $display("%0t traffic did not drain, %0d bytes still expected", $time, exp_q.size());
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      if (errors == err_start)
         $display("%0t %s: ok", $time, name);
      else
         $display("%0t %s: %0d errors", $time, name, errors - err_start);
   endtask

   //####################
   // Source, sink, model
   //####################

   always @(negedge sys_clk)
   begin
      erx_data_t d;
      erx_byte_t exp;
      soft_reset   <= ctl_soft;
      pll_locked   <= ctl_lock;
      idelay_ready <= ctl_idly;
      out_credit   <= rx_nreset_in && ($unsigned($random(seed)) % 100 < snk_rate);
      if (in_credit === 1'b1)
      begin
         src_cnt++;
         ret_cnt++;
      end
      if (out_byte.valid === 1'b1)
      begin
         dlv_cnt++;
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("%0t byte %h came out with nothing outstanding", $time, out_byte.data);
         end
         else
         begin
            exp = '{valid: 1'b1, data: exp_q.pop_front()};
            check_byte("out_byte", exp, out_byte);
         end
      end
      if (rx_active && !prev_active)
         src_cnt = `ERX_SRC_CREDITS;            // Fresh credits on activation
      else if (!rx_active)
      begin
         src_cnt = 0;                           // Credits in flight lost
         exp_q.delete();                        // Lanes flushed
      end
      else
         check_count("credit_sum", `ERX_SRC_CREDITS, src_cnt + exp_q.size());
      prev_active = rx_active;
      if (rx_active && sent < send_lim && src_cnt > 0 && $unsigned($random(seed)) % 100 < 60)
      begin
         d = erx_data_t'($random(seed));
         in_byte <= '{valid: 1'b1, data: d};
         exp_q.push_back(d);
         src_cnt--;
         sent++;
      end
      else
         in_byte <= '{valid: 1'b0, data: erx_data_t'($random(seed))};   // Junk data, ignored
   end

   //####################
   // Test sequence
   //####################

   initial
   begin
      int t_err;
      int base;
      int n;
      rx_nreset_in <= 1'b0;
      repeat (8) @(posedge sys_clk);
      @(negedge sys_clk);
      rx_nreset_in <= 1'b1;

      // Bring-up, lock and delay ready held low
      t_err = errors;
      repeat (4) step();
      check_state("pll_reset", 1'b1, pll_reset);
      ctl_soft = 1'b0;
      n = 0;
      while (pll_reset !== 1'b0 && n < 2000)
      begin
         step();
         n++;
      end
      if (pll_reset !== 1'b0)
      begin
         errors++;
         $display("%0t pll_reset stayed high after soft_reset cleared", $time);
      end
      for (int i = 0; i < 64; i++)
      begin
         step();
         check_state("rx_active", 1'b0, rx_active);
      end
      ctl_lock = 1'b1;
      ctl_idly = 1'b1;
      wait_active(1'b1, 48);                   // Three beats
      report_test("bring-up", t_err);

      // Back-pressure, sink silent
      t_err = errors;
      base = sent;
      send_lim = sent + 40;
      n = 0;
      while (src_cnt != 0 && n < 2000)
      begin
         step();
         n++;
      end
      if (src_cnt != 0)
      begin
         errors++;
         $display("%0t source never ran out of credits", $time);
      end
      repeat (40) step();
      check_count("bytes_sent", `ERX_SRC_CREDITS, sent - base);
      check_count("bytes_out", 0, dlv_cnt);
      send_lim = sent;
      snk_rate = 50;
      wait_drain();
      check_count("bytes_out", `ERX_SRC_CREDITS, dlv_cnt);
      report_test("back-pressure", t_err);

      // Ordering, generous sink
      t_err = errors;
      base = dlv_cnt;
      snk_rate = 90;
      send_lim = sent + 500;
      wait_drain();
      check_count("bytes_out", 500, dlv_cnt - base);
      report_test("ordering", t_err);

      // Credit conservation, slow sink phase
      t_err = errors;
      snk_rate = 25;
      send_lim = sent + 200;
      wait_drain();
      check_count("in_credit_total", dlv_cnt, ret_cnt);
      report_test("credit conservation", t_err);

      // Soft reset with traffic in flight
      t_err = errors;
      snk_rate = 60;
      send_lim = sent + 300;
      repeat (30) step();
      ctl_soft = 1'b1;
      wait_active(1'b0, 18);                   // One beat plus drive delay
      send_lim = sent;
      base = dlv_cnt;
      repeat (40) step();
      check_count("bytes_out", base, dlv_cnt);
      check_state("pll_reset", 1'b1, pll_reset);   // Sequencer back at the start
      ctl_soft = 1'b0;
      wait_active(1'b1, 48);
      base = dlv_cnt;
      send_lim = sent + 100;
      wait_drain();
      check_count("bytes_out", 100, dlv_cnt - base);
      report_test("soft reset", t_err);

      $display("checks %0d, errors %0d, bytes out %0d", checks, errors, dlv_cnt);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: tb.f
+incdir+design
design/erx_pkg.sv
design/erx_reset_seq.sv
design/erx_lane_dist.sv
design/erx_lane.sv
design/erx_lane_merge.sv
design/erx_top.sv
dv/erx_sva.sv
dv/erx_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= erx_tb
SEED_ARGS ?= +verilator+seed+1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

SRCS := $(shell grep -v '^+' tb.f) design/erx_macros.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): tb.f $(SRCS)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f tb.f

run: $(BIN)
	./$(BIN) $(SEED_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
